// File: common/be_pkg.sv
// Shared widths, encodings and packets; the 16-bit address and 8-entry counter table are fixed

package be_pkg;

  // Address and boot
  localparam int unsigned VADDR_W = 16;
  localparam logic [VADDR_W-1:0] BOOT_PC = 16'h0100;
  localparam logic [VADDR_W-1:0] PC_STEP = 16'd4;

  // Branch counter table
  localparam int unsigned BHT_IDX_W = 3;
  localparam int unsigned BHT_ELS = 1 << BHT_IDX_W;
  localparam int unsigned BHT_CTR_W = 2;
  localparam logic [BHT_CTR_W-1:0] BHT_CTR_INIT = 2'b01;

  // Command queue
  localparam int unsigned FE_CMD_ELS = 2;
  localparam int unsigned FE_CMD_PTR_W = $clog2(FE_CMD_ELS);
  localparam int unsigned FE_CMD_CNT_W = $clog2(FE_CMD_ELS + 1);

  typedef enum logic [2:0]
  {
    e_op_state_reset          = 3'd0,
    e_op_pc_redirection       = 3'd1,
    e_op_icache_fence         = 3'd2,
    e_op_icache_fill_response = 3'd3,
    e_op_attaboy              = 3'd4
  } fe_opcode_e;

  typedef enum logic [1:0]
  {
    e_subop_trap             = 2'd0,
    e_subop_eret             = 2'd1,
    e_subop_branch_mispredict = 2'd2
  } redirect_subop_e;

  typedef enum logic [1:0]
  {
    e_not_a_branch          = 2'd0,
    e_incorrect_pred_taken  = 2'd1,
    e_incorrect_pred_ntaken = 2'd2
  } mispredict_reason_e;

  typedef enum logic [1:0]
  {
    e_reset = 2'd0,
    e_boot  = 2'd1,
    e_run   = 2'd2,
    e_fence = 2'd3
  } director_state_e;

  // Instruction currently leaving issue
  typedef struct packed
  {
    logic                 v;
    logic [VADDR_W-1:0]   pc;
    logic [BHT_IDX_W-1:0] bht_idx;
  } isd_status_s;

  // Resolved branch or jump
  typedef struct packed
  {
    logic               v;
    logic               branch;
    logic               btaken;
    logic [VADDR_W-1:0] npc;
  } branch_pkt_s;

  // Commit-time events; npc is the redirect target for every flag
  typedef struct packed
  {
    logic               npc_w_v;
    logic [VADDR_W-1:0] npc;
    logic               exception;
    logic               eret;
    logic               fencei;
    logic               icache_miss;
  } commit_pkt_s;

  // Command from the back end to the front end
  typedef struct packed
  {
    fe_opcode_e           opcode;
    logic [VADDR_W-1:0]   vaddr;
    redirect_subop_e      subop;
    mispredict_reason_e   reason;
    logic                 taken;
    logic [BHT_IDX_W-1:0] bht_idx;
  } fe_cmd_s;

endpackage

// File: be_director/be_director.sv
// Commands are offered only while cmd_ready_i is high; one command per cycle at most
`timescale 1ns/1ps

module be_director
  (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        freeze_i,
    input  be_pkg::isd_status_s         isd_status_i,
    input  be_pkg::branch_pkt_s         br_pkt_i,
    input  be_pkg::commit_pkt_s         commit_pkt_i,
    input  logic                        cmd_ready_i,
    output be_pkg::fe_cmd_s             cmd_o,
    output logic                        cmd_v_o,
    output logic [be_pkg::VADDR_W-1:0]  expected_npc_o,
    output logic                        poison_isd_o,
    output logic                        suppress_iss_o
  );

  be_pkg::director_state_e state_r;
  be_pkg::director_state_e state_n;

  logic [be_pkg::VADDR_W-1:0] npc_r;
  logic [be_pkg::VADDR_W-1:0] npc_n;
  logic                       npc_w_v;
  logic                       npc_mismatch_v;

  logic branch_pending_r;
  logic btaken_pending_r;
  logic last_was_branch;
  logic last_was_btaken;

  be_pkg::fe_cmd_s cmd_n;
  logic            cmd_req;
  logic            cmd_nonattaboy_v;

  // Commit update wins over a branch update
  assign npc_w_v = commit_pkt_i.npc_w_v | br_pkt_i.v;
  assign npc_n = commit_pkt_i.npc_w_v ? commit_pkt_i.npc : br_pkt_i.npc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      npc_r <= be_pkg::BOOT_PC;
    end
    else if (state_r == be_pkg::e_reset)
    begin
      // Held at the boot PC while frozen so a reboot starts clean
      npc_r <= be_pkg::BOOT_PC;
    end
    else if (npc_w_v)
    begin
      npc_r <= npc_n;
    end
  end

  assign expected_npc_o = npc_w_v ? npc_n : npc_r;

  assign npc_mismatch_v = isd_status_i.v & (expected_npc_o != isd_status_i.pc);
  assign poison_isd_o = npc_mismatch_v;

  // Branch info of the last resolved instruction, consumed by the next issue
  always_ff @(posedge clk_i)
  begin
    if (reset_i | isd_status_i.v)
    begin
      branch_pending_r <= 1'b0;
      btaken_pending_r <= 1'b0;
    end
    else if (br_pkt_i.v)
    begin
      branch_pending_r <= br_pkt_i.branch;
      btaken_pending_r <= br_pkt_i.btaken;
    end
  end

  assign last_was_branch = br_pkt_i.v ? br_pkt_i.branch : branch_pending_r;
  assign last_was_btaken = br_pkt_i.v ? br_pkt_i.btaken : btaken_pending_r;

  // Pick the highest-priority event of this cycle
  always_comb
  begin
    cmd_n = '0;
    cmd_req = 1'b0;

    if (state_r == be_pkg::e_boot)
    begin
      cmd_n.opcode = be_pkg::e_op_state_reset;
      cmd_n.vaddr = be_pkg::BOOT_PC;
      cmd_req = 1'b1;
    end
    else if (state_r == be_pkg::e_reset)
    begin
      cmd_req = 1'b0;
    end
    else if (commit_pkt_i.fencei)
    begin
      cmd_n.opcode = be_pkg::e_op_icache_fence;
      cmd_n.vaddr = commit_pkt_i.npc;
      cmd_req = 1'b1;
    end
    else if (commit_pkt_i.icache_miss)
    begin
      cmd_n.opcode = be_pkg::e_op_icache_fill_response;
      cmd_n.vaddr = commit_pkt_i.npc;
      cmd_req = 1'b1;
    end
    else if (commit_pkt_i.eret)
    begin
      cmd_n.opcode = be_pkg::e_op_pc_redirection;
      cmd_n.vaddr = commit_pkt_i.npc;
      cmd_n.subop = be_pkg::e_subop_eret;
      cmd_req = 1'b1;
    end
    else if (commit_pkt_i.exception)
    begin
      cmd_n.opcode = be_pkg::e_op_pc_redirection;
      cmd_n.vaddr = commit_pkt_i.npc;
      cmd_n.subop = be_pkg::e_subop_trap;
      cmd_req = 1'b1;
    end
    else if (npc_mismatch_v)
    begin
      cmd_n.opcode = be_pkg::e_op_pc_redirection;
      cmd_n.vaddr = expected_npc_o;
      cmd_n.subop = be_pkg::e_subop_branch_mispredict;
      cmd_n.bht_idx = isd_status_i.bht_idx;
      if (!last_was_branch)
      begin
        cmd_n.reason = be_pkg::e_not_a_branch;
      end
      else if (last_was_btaken)
      begin
        cmd_n.reason = be_pkg::e_incorrect_pred_taken;
      end
      else
      begin
        cmd_n.reason = be_pkg::e_incorrect_pred_ntaken;
      end
      cmd_req = 1'b1;
    end
    else if (isd_status_i.v & last_was_branch)
    begin
      // Prediction held up, reinforce it
      cmd_n.opcode = be_pkg::e_op_attaboy;
      cmd_n.vaddr = expected_npc_o;
      cmd_n.taken = last_was_btaken;
      cmd_n.bht_idx = isd_status_i.bht_idx;
      cmd_req = 1'b1;
    end
  end

  assign cmd_o = cmd_n;
  assign cmd_v_o = cmd_req & cmd_ready_i;
  assign cmd_nonattaboy_v = cmd_v_o & (cmd_n.opcode != be_pkg::e_op_attaboy);

  // Queue still backed up after a redirect
  assign suppress_iss_o = (state_r == be_pkg::e_fence) & ~cmd_ready_i;

  always_comb
  begin
    case (state_r)
      be_pkg::e_reset: state_n = freeze_i ? be_pkg::e_reset : be_pkg::e_boot;
      be_pkg::e_boot:  state_n = cmd_v_o ? be_pkg::e_run : be_pkg::e_boot;
      be_pkg::e_run:
      begin
        if (freeze_i)
        begin
          state_n = be_pkg::e_reset;
        end
        else if (cmd_nonattaboy_v)
        begin
          state_n = be_pkg::e_fence;
        end
        else
        begin
          state_n = be_pkg::e_run;
        end
      end
      be_pkg::e_fence: state_n = suppress_iss_o ? be_pkg::e_fence : be_pkg::e_run;
      default:         state_n = be_pkg::e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= be_pkg::e_reset;
    end
    else
    begin
      state_r <= state_n;
    end
  end

endmodule

// File: rtl/fe_cmd_fifo.sv
// A write while full is ignored, so v_i must follow ready_o
`timescale 1ns/1ps

module fe_cmd_fifo
  (
    input  logic            clk_i,
    input  logic            reset_i,
    input  be_pkg::fe_cmd_s data_i,
    input  logic            v_i,
    output logic            ready_o,
    output be_pkg::fe_cmd_s data_o,
    output logic            v_o,
    input  logic            yumi_i,
    output logic            full_o
  );

  be_pkg::fe_cmd_s mem_r [be_pkg::FE_CMD_ELS];

  logic [be_pkg::FE_CMD_PTR_W-1:0] wr_ptr_r;
  logic [be_pkg::FE_CMD_PTR_W-1:0] rd_ptr_r;
  logic [be_pkg::FE_CMD_CNT_W-1:0] count_r;
  logic                            wr_v;
  logic                            rd_v;

  assign ready_o = (count_r != be_pkg::FE_CMD_CNT_W'(be_pkg::FE_CMD_ELS));
  assign full_o = ~ready_o;
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  assign wr_v = v_i & ready_o;
  assign rd_v = yumi_i & v_o;

  // Entry storage
  always_ff @(posedge clk_i)
  begin
    if (wr_v)
    begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end
    else
    begin
      if (wr_v)
      begin
        wr_ptr_r <= (wr_ptr_r == be_pkg::FE_CMD_PTR_W'(be_pkg::FE_CMD_ELS - 1))
                    ? '0 : wr_ptr_r + 1'b1;
      end
      if (rd_v)
      begin
        rd_ptr_r <= (rd_ptr_r == be_pkg::FE_CMD_PTR_W'(be_pkg::FE_CMD_ELS - 1))
                    ? '0 : rd_ptr_r + 1'b1;
      end
      // Simultaneous write and read leave the count unchanged
      if (wr_v & ~rd_v)
      begin
        count_r <= count_r + 1'b1;
      end
      else if (rd_v & ~wr_v)
      begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

// File: rtl/fe_pc_gen.sv
// Fetch is sequential by 4 bytes; no predicted-taken redirect, counters only train and report
`timescale 1ns/1ps

module fe_pc_gen
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  be_pkg::fe_cmd_s               cmd_i,
    input  logic                          cmd_v_i,
    output logic                          cmd_yumi_o,
    input  logic                          fetch_stall_i,
    input  logic [be_pkg::BHT_IDX_W-1:0]  bht_query_idx_i,
    output logic [be_pkg::VADDR_W-1:0]    fetch_pc_o,
    output logic                          fetch_v_o,
    output logic                          pred_taken_o
  );

  logic [be_pkg::BHT_CTR_W-1:0] bht_r [be_pkg::BHT_ELS];
  logic [be_pkg::BHT_CTR_W-1:0] ctr_cur;
  logic [be_pkg::BHT_CTR_W-1:0] ctr_next;
  logic [be_pkg::VADDR_W-1:0]   fetch_pc_r;
  logic                         fetch_v_r;
  logic                         is_attaboy;
  logic                         is_state_reset;
  logic                         is_mispredict;
  logic                         ctr_inc;
  logic                         ctr_dec;

  // Head is consumed whenever fetch is not stalled
  assign cmd_yumi_o = cmd_v_i & ~fetch_stall_i;

  assign is_attaboy = (cmd_i.opcode == be_pkg::e_op_attaboy);
  assign is_state_reset = (cmd_i.opcode == be_pkg::e_op_state_reset);
  assign is_mispredict = (cmd_i.opcode == be_pkg::e_op_pc_redirection)
                       & (cmd_i.subop == be_pkg::e_subop_branch_mispredict);

  // Training direction
  always_comb
  begin
    ctr_inc = 1'b0;
    ctr_dec = 1'b0;
    if (cmd_yumi_o & is_attaboy)
    begin
      ctr_inc = cmd_i.taken;
      ctr_dec = ~cmd_i.taken;
    end
    else if (cmd_yumi_o & is_mispredict)
    begin
      // Not-a-branch leaves the counter alone
      ctr_inc = (cmd_i.reason == be_pkg::e_incorrect_pred_ntaken);
      ctr_dec = (cmd_i.reason == be_pkg::e_incorrect_pred_taken);
    end
  end

  assign ctr_cur = bht_r[cmd_i.bht_idx];

  // Saturating update
  always_comb
  begin
    ctr_next = ctr_cur;
    if (ctr_inc && (ctr_cur != '1))
    begin
      ctr_next = ctr_cur + 1'b1;
    end
    else if (ctr_dec && (ctr_cur != '0))
    begin
      ctr_next = ctr_cur - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      fetch_v_r <= 1'b0;
      fetch_pc_r <= '0;
    end
    else
    begin
      if (cmd_yumi_o & ~is_attaboy)
      begin
        fetch_pc_r <= cmd_i.vaddr;
      end
      else if (fetch_v_r & ~fetch_stall_i)
      begin
        fetch_pc_r <= fetch_pc_r + be_pkg::PC_STEP;
      end
      if (cmd_yumi_o & is_state_reset)
      begin
        fetch_v_r <= 1'b1;
      end
    end
  end

  // Counters start weakly not-taken
  always_ff @(posedge clk_i)
  begin
    if (reset_i | (cmd_yumi_o & is_state_reset))
    begin
      for (int i = 0; i < be_pkg::BHT_ELS; i++)
      begin
        bht_r[i] <= be_pkg::BHT_CTR_INIT;
      end
    end
    else if (ctr_inc | ctr_dec)
    begin
      bht_r[cmd_i.bht_idx] <= ctr_next;
    end
  end

  assign fetch_pc_o = fetch_pc_r;
  assign fetch_v_o = fetch_v_r;
  assign pred_taken_o = bht_r[bht_query_idx_i][be_pkg::BHT_CTR_W-1];

endmodule

// File: rtl/be_fe_top.sv
// Issue, branch and commit inputs are sampled every cycle; keep events off while fe_cmd_full_o
`timescale 1ns/1ps

module be_fe_top
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          freeze_i,
    input  be_pkg::isd_status_s           issue_status_i,
    input  be_pkg::branch_pkt_s           br_pkt_i,
    input  be_pkg::commit_pkt_s           commit_pkt_i,
    input  logic                          fetch_stall_i,
    input  logic [be_pkg::BHT_IDX_W-1:0]  bht_query_idx_i,
    output logic [be_pkg::VADDR_W-1:0]    expected_npc_o,
    output logic                          poison_isd_o,
    output logic                          suppress_iss_o,
    output logic                          fe_cmd_full_o,
    output logic [be_pkg::VADDR_W-1:0]    fetch_pc_o,
    output logic                          fetch_v_o,
    output logic                          pred_taken_o
  );

  be_pkg::fe_cmd_s dir_cmd;
  logic            dir_cmd_v;
  logic            fifo_ready;
  be_pkg::fe_cmd_s fe_cmd;
  logic            fe_cmd_v;
  logic            fe_cmd_yumi;

  be_director be_director_inst
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .freeze_i       (freeze_i),
    .isd_status_i   (issue_status_i),
    .br_pkt_i       (br_pkt_i),
    .commit_pkt_i   (commit_pkt_i),
    .cmd_ready_i    (fifo_ready),
    .cmd_o          (dir_cmd),
    .cmd_v_o        (dir_cmd_v),
    .expected_npc_o (expected_npc_o),
    .poison_isd_o   (poison_isd_o),
    .suppress_iss_o (suppress_iss_o)
  );

  fe_cmd_fifo fe_cmd_fifo_inst
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (dir_cmd),
    .v_i     (dir_cmd_v),
    .ready_o (fifo_ready),
    .data_o  (fe_cmd),
    .v_o     (fe_cmd_v),
    .yumi_i  (fe_cmd_yumi),
    .full_o  (fe_cmd_full_o)
  );

  fe_pc_gen fe_pc_gen_inst
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_i           (fe_cmd),
    .cmd_v_i         (fe_cmd_v),
    .cmd_yumi_o      (fe_cmd_yumi),
    .fetch_stall_i   (fetch_stall_i),
    .bht_query_idx_i (bht_query_idx_i),
    .fetch_pc_o      (fetch_pc_o),
    .fetch_v_o       (fetch_v_o),
    .pred_taken_o    (pred_taken_o)
  );

endmodule

// File: sim/tb_be_fe_top.sv
// Checks against cycle models of the director, queue and fetch unit; inputs change on rising edges
`timescale 1ns/1ps

module tb_be_fe_top;

  localparam int TRAIN_EVENTS = 48;
  localparam int SCRIPT_CYCLES = 100 + 2 * TRAIN_EVENTS;
  localparam int TIMEOUT_CYCLES = 2 * SCRIPT_CYCLES;
  localparam logic [15:0] LFSR_SEED = 16'd30252;

  logic                       clk_i;
  logic                       reset_i;
  logic                       freeze_i;
  be_pkg::isd_status_s        issue_status_i;
  be_pkg::branch_pkt_s        br_pkt_i;
  be_pkg::commit_pkt_s        commit_pkt_i;
  logic                       fetch_stall_i;
  logic [be_pkg::BHT_IDX_W-1:0] bht_query_idx_i;
  logic [be_pkg::VADDR_W-1:0] expected_npc_o;
  logic                       poison_isd_o;
  logic                       suppress_iss_o;
  logic                       fe_cmd_full_o;
  logic [be_pkg::VADDR_W-1:0] fetch_pc_o;
  logic                       fetch_v_o;
  logic                       pred_taken_o;

  // Reference model state
  be_pkg::director_state_e m_state;
  logic [15:0]             m_npc;
  logic                    m_br_pend;
  logic                    m_bt_pend;
  logic                    m_fetch_v;
  logic [15:0]             m_fetch_pc;
  logic [1:0]              m_bht [8];
  be_pkg::fe_cmd_s         fifo_q [$];

  logic [15:0] lfsr;
  int          errors;
  int          cycle_cnt;

  be_fe_top be_fe_top_inst
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .freeze_i        (freeze_i),
    .issue_status_i  (issue_status_i),
    .br_pkt_i        (br_pkt_i),
    .commit_pkt_i    (commit_pkt_i),
    .fetch_stall_i   (fetch_stall_i),
    .bht_query_idx_i (bht_query_idx_i),
    .expected_npc_o  (expected_npc_o),
    .poison_isd_o    (poison_isd_o),
    .suppress_iss_o  (suppress_iss_o),
    .fe_cmd_full_o   (fe_cmd_full_o),
    .fetch_pc_o      (fetch_pc_o),
    .fetch_v_o       (fetch_v_o),
    .pred_taken_o    (pred_taken_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  // Fibonacci LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val = {val[14:0], fb};
    end
    return val;
  endfunction

  function automatic logic [15:0] rand_pc();
    return {14'(rand_bits(14)), 2'b00};
  endfunction

  function automatic be_pkg::isd_status_s issue_at(input logic [15:0] pc, input logic [2:0] idx);
    be_pkg::isd_status_s s;
    s = '0;
    s.v = 1'b1;
    s.pc = pc;
    s.bht_idx = idx;
    return s;
  endfunction

  function automatic be_pkg::branch_pkt_s resolved_branch(input logic is_br, input logic taken,
                                                          input logic [15:0] npc);
    be_pkg::branch_pkt_s b;
    b.v = 1'b1;
    b.branch = is_br;
    b.btaken = taken;
    b.npc = npc;
    return b;
  endfunction

  // Expected PC seen this cycle with the commit update first
  function automatic logic [15:0] exp_npc_now();
    if (commit_pkt_i.npc_w_v)
    begin
      return commit_pkt_i.npc;
    end
    if (br_pkt_i.v)
    begin
      return br_pkt_i.npc;
    end
    return m_npc;
  endfunction

  task automatic reset_counters();
    for (int j = 0; j < 8; j++)
    begin
      m_bht[j] = 2'b01;
    end
  endtask

  task automatic train_counter(input logic [2:0] idx, input logic up);
    if (up && (m_bht[idx] != 2'b11))
    begin
      m_bht[idx] = m_bht[idx] + 2'b01;
    end
    else if (!up && (m_bht[idx] != 2'b00))
    begin
      m_bht[idx] = m_bht[idx] - 2'b01;
    end
  endtask

  // Front end takes one command
  task automatic apply_cmd(input be_pkg::fe_cmd_s cmd, output logic loaded);
    loaded = (cmd.opcode != be_pkg::e_op_attaboy);
    if (loaded)
    begin
      m_fetch_pc = cmd.vaddr;
    end
    if (cmd.opcode == be_pkg::e_op_state_reset)
    begin
      m_fetch_v = 1'b1;
      reset_counters();
    end
    else if (cmd.opcode == be_pkg::e_op_attaboy)
    begin
      train_counter(cmd.bht_idx, cmd.taken);
    end
    else if ((cmd.opcode == be_pkg::e_op_pc_redirection)
             && (cmd.subop == be_pkg::e_subop_branch_mispredict)
             && (cmd.reason != be_pkg::e_not_a_branch))
    begin
      train_counter(cmd.bht_idx, cmd.reason == be_pkg::e_incorrect_pred_ntaken);
    end
  endtask

  always @(posedge clk_i)
  begin : model_step
    be_pkg::fe_cmd_s cmd;
    logic [15:0]     exp_now;
    logic            cmd_req;
    logic            cmd_sent;
    logic            full;
    logic            last_br;
    logic            last_bt;
    logic            loaded;
    if (reset_i)
    begin
      m_state = be_pkg::e_reset;
      m_npc = be_pkg::BOOT_PC;
      m_br_pend = 1'b0;
      m_bt_pend = 1'b0;
      m_fetch_v = 1'b0;
      m_fetch_pc = '0;
      fifo_q.delete();
      reset_counters();
    end
    else
    begin
      full = (fifo_q.size() == be_pkg::FE_CMD_ELS);
      exp_now = exp_npc_now();
      last_br = br_pkt_i.v ? br_pkt_i.branch : m_br_pend;
      last_bt = br_pkt_i.v ? br_pkt_i.btaken : m_bt_pend;
      cmd = '0;
      cmd_req = 1'b1;
      if (m_state == be_pkg::e_boot)
      begin
        cmd.opcode = be_pkg::e_op_state_reset;
        cmd.vaddr = be_pkg::BOOT_PC;
      end
      else if (m_state == be_pkg::e_reset)
      begin
        cmd_req = 1'b0;
      end
      else if (commit_pkt_i.fencei)
      begin
        cmd.opcode = be_pkg::e_op_icache_fence;
        cmd.vaddr = commit_pkt_i.npc;
      end
      else if (commit_pkt_i.icache_miss)
      begin
        cmd.opcode = be_pkg::e_op_icache_fill_response;
        cmd.vaddr = commit_pkt_i.npc;
      end
      else if (commit_pkt_i.eret || commit_pkt_i.exception)
      begin
        cmd.opcode = be_pkg::e_op_pc_redirection;
        cmd.vaddr = commit_pkt_i.npc;
        cmd.subop = commit_pkt_i.eret ? be_pkg::e_subop_eret : be_pkg::e_subop_trap;
      end
      else if (issue_status_i.v && (issue_status_i.pc != exp_now))
      begin
        cmd.opcode = be_pkg::e_op_pc_redirection;
        cmd.vaddr = exp_now;
        cmd.subop = be_pkg::e_subop_branch_mispredict;
        cmd.bht_idx = issue_status_i.bht_idx;
        if (!last_br)
        begin
          cmd.reason = be_pkg::e_not_a_branch;
        end
        else
        begin
          cmd.reason = last_bt ? be_pkg::e_incorrect_pred_taken : be_pkg::e_incorrect_pred_ntaken;
        end
      end
      else if (issue_status_i.v && last_br)
      begin
        cmd.opcode = be_pkg::e_op_attaboy;
        cmd.vaddr = exp_now;
        cmd.taken = last_bt;
        cmd.bht_idx = issue_status_i.bht_idx;
      end
      else
      begin
        cmd_req = 1'b0;
      end
      cmd_sent = cmd_req && !full;

      loaded = 1'b0;
      if (!fetch_stall_i)
      begin
        if (fifo_q.size() > 0)
        begin
          apply_cmd(fifo_q.pop_front(), loaded);
        end
        // An attaboy leaves fetch running sequentially
        if (!loaded && m_fetch_v)
        begin
          m_fetch_pc = m_fetch_pc + 16'd4;
        end
      end
      if (cmd_sent)
      begin
        fifo_q.push_back(cmd);
      end

      m_npc = (m_state == be_pkg::e_reset) ? be_pkg::BOOT_PC : exp_now;
      if (issue_status_i.v)
      begin
        m_br_pend = 1'b0;
        m_bt_pend = 1'b0;
      end
      else if (br_pkt_i.v)
      begin
        m_br_pend = br_pkt_i.branch;
        m_bt_pend = br_pkt_i.btaken;
      end

      case (m_state)
        be_pkg::e_reset: m_state = freeze_i ? be_pkg::e_reset : be_pkg::e_boot;
        be_pkg::e_boot:  m_state = cmd_sent ? be_pkg::e_run : be_pkg::e_boot;
        be_pkg::e_run:
        begin
          if (freeze_i)
          begin
            m_state = be_pkg::e_reset;
          end
          else if (cmd_sent && (cmd.opcode != be_pkg::e_op_attaboy))
          begin
            m_state = be_pkg::e_fence;
          end
        end
        be_pkg::e_fence: m_state = full ? be_pkg::e_fence : be_pkg::e_run;
        default:         m_state = be_pkg::e_reset;
      endcase
    end
  end

  // Compare DUT outputs with the models
  always @(negedge clk_i)
  begin : check_outputs
    logic [15:0] exp_now;
    exp_now = exp_npc_now();
    assert (fetch_v_o === m_fetch_v)
      else report_error($sformatf("fetch_v_o is %b, expected %b", fetch_v_o, m_fetch_v));
    if (m_fetch_v)
    begin
      assert (fetch_pc_o === m_fetch_pc)
        else report_error($sformatf("fetch_pc_o is %h, expected %h", fetch_pc_o, m_fetch_pc));
    end
    if (!reset_i)
    begin
      assert (expected_npc_o === exp_now)
        else report_error($sformatf("expected_npc_o is %h, expected %h", expected_npc_o, exp_now));
      assert (poison_isd_o === (issue_status_i.v && (issue_status_i.pc != exp_now)))
        else report_error($sformatf("poison_isd_o is %b for issue pc %h, expected pc %h",
                                    poison_isd_o, issue_status_i.pc, exp_now));
      assert (fe_cmd_full_o === (fifo_q.size() == be_pkg::FE_CMD_ELS))
        else report_error($sformatf("fe_cmd_full_o is %b with %0d queued", fe_cmd_full_o,
                                    fifo_q.size()));
      assert (suppress_iss_o === ((m_state == be_pkg::e_fence)
                                  && (fifo_q.size() == be_pkg::FE_CMD_ELS)))
        else report_error($sformatf("suppress_iss_o is %b", suppress_iss_o));
      assert (pred_taken_o === m_bht[bht_query_idx_i][1])
        else report_error($sformatf("pred_taken_o is %b at index %0d, counter %b", pred_taken_o,
                                    bht_query_idx_i, m_bht[bht_query_idx_i]));
    end
  end

  task automatic drive(input be_pkg::isd_status_s iss, input be_pkg::branch_pkt_s br,
                       input be_pkg::commit_pkt_s cm);
    @(posedge clk_i);
    issue_status_i <= iss;
    br_pkt_i <= br;
    commit_pkt_i <= cm;
    bht_query_idx_i <= 3'(rand_bits(3));
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0, '0, '0);
  endtask

  task automatic wait_boot(input int limit);
    int n;
    n = 0;
    while (!(fetch_v_o && (fetch_pc_o == be_pkg::BOOT_PC)) && (n < limit))
    begin
      @(negedge clk_i);
      n++;
    end
    assert (fetch_v_o && (fetch_pc_o == be_pkg::BOOT_PC))
      else
      begin
        errors++;
        $display("Fetch did not start at the boot PC within %0d cycles", limit);
      end
  endtask

  task automatic sweep_counters(input logic after_boot);
    for (int q = 0; q < 8; q++)
    begin
      @(posedge clk_i);
      bht_query_idx_i <= 3'(q);
      @(negedge clk_i);
      assert (pred_taken_o === m_bht[q][1])
        else report_error($sformatf("counter %0d predicts %b", q, pred_taken_o));
      if (after_boot)
      begin
        assert (!pred_taken_o)
          else report_error($sformatf("counter %0d not weakly not-taken after boot", q));
      end
    end
  endtask

  initial
  begin : stimulus
    logic [15:0]         t;
    logic [15:0]         u;
    logic [15:0]         prev_npc;
    logic [1:0]          kind;
    logic [2:0]          idx;
    be_pkg::commit_pkt_s cm;
    lfsr = LFSR_SEED;
    errors = 0;
    reset_i <= 1'b1;
    freeze_i <= 1'b1;
    issue_status_i <= '0;
    br_pkt_i <= '0;
    commit_pkt_i <= '0;
    fetch_stall_i <= 1'b0;
    bht_query_idx_i <= '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // Boot held off while frozen
    idle(4);
    @(negedge clk_i);
    assert (!fetch_v_o) else report_error("fetch_v_o high while frozen");
    idle(1);
    freeze_i <= 1'b0;
    wait_boot(16);
    @(negedge clk_i);
    assert (fetch_pc_o == be_pkg::BOOT_PC + 16'd4)
      else report_error($sformatf("fetch_pc_o %h did not step by 4 after boot", fetch_pc_o));

    // Mispredict redirect, then a correct prediction
    t = rand_pc();
    drive('0, resolved_branch(1'b1, 1'b1, t), '0);
    drive(issue_at(t + 16'h8, 3'(rand_bits(3))), '0, '0);
    @(negedge clk_i);
    assert (poison_isd_o) else report_error("poison_isd_o low on a mismatching issue");
    idle(2);
    @(negedge clk_i);
    assert (fetch_pc_o == t)
      else report_error($sformatf("redirect gave fetch_pc_o %h, expected %h", fetch_pc_o, t));
    u = rand_pc();
    drive(issue_at(u, 3'(rand_bits(3))), resolved_branch(1'b1, 1'b0, u), '0);
    @(negedge clk_i);
    assert (!poison_isd_o) else report_error("poison_isd_o high on a matching issue");
    idle(2);

    // Counter training on random indices
    for (int i = 0; i < TRAIN_EVENTS; i++)
    begin
      kind = 2'(rand_bits(2));
      idx = 3'(rand_bits(3));
      t = rand_pc();
      if (kind < 2'd2)
      begin
        drive(issue_at(t, idx), resolved_branch(1'b1, kind[0], t), '0);
      end
      else
      begin
        drive(issue_at(t ^ 16'h0010, idx), resolved_branch(~kind[0], rand_bits(1) != 0, t), '0);
      end
      idle(1);
    end
    idle(2);
    sweep_counters(1'b0);

    // Commit events outrank a mispredict in the same cycle
    for (int k = 0; k < 5; k++)
    begin
      prev_npc = m_npc;
      t = rand_pc();
      if (t == prev_npc)
      begin
        t = t ^ 16'h0040;
      end
      cm = '0;
      // Odd cases keep the old expected PC so a mispredict would go elsewhere
      cm.npc_w_v = ((k % 2) == 0);
      cm.npc = t;
      cm.exception = (k == 0) || (k == 4);
      cm.eret = (k == 1) || (k == 4);
      cm.fencei = (k == 2) || (k == 4);
      cm.icache_miss = (k == 3) || (k == 4);
      u = cm.npc_w_v ? t : prev_npc;
      drive(issue_at(u + 16'h20, 3'(rand_bits(3))), '0, cm);
      idle(2);
      @(negedge clk_i);
      assert ((fetch_pc_o == t) && (expected_npc_o == u))
        else report_error($sformatf("commit case %0d gave fetch_pc_o %h and expected_npc_o %h",
                                    k, fetch_pc_o, expected_npc_o));
    end

    // Two redirects queued behind a stalled fetch
    idle(1);
    fetch_stall_i <= 1'b1;
    t = rand_pc();
    u = rand_pc();
    cm = '0;
    cm.npc_w_v = 1'b1;
    cm.npc = u;
    cm.exception = 1'b1;
    drive('0, resolved_branch(1'b1, 1'b0, t), '0);
    drive(issue_at(t + 16'h8, 3'(rand_bits(3))), '0, '0);
    idle(1);
    drive('0, '0, cm);
    idle(1);
    @(negedge clk_i);
    assert (fe_cmd_full_o && suppress_iss_o) else report_error("queue not full and fenced");
    idle(2);
    @(negedge clk_i);
    assert (suppress_iss_o) else report_error("suppress_iss_o dropped while stalled");
    idle(1);
    fetch_stall_i <= 1'b0;
    idle(1);
    @(negedge clk_i);
    assert (fetch_pc_o == t)
      else report_error($sformatf("first redirect gave %h, expected %h", fetch_pc_o, t));
    idle(1);
    @(negedge clk_i);
    assert (fetch_pc_o == u)
      else report_error($sformatf("second redirect gave %h, expected %h", fetch_pc_o, u));

    // Freeze stops commands, release reboots
    idle(3);
    freeze_i <= 1'b1;
    drive(issue_at(16'h0004, 3'd0), '0, '0);
    @(negedge clk_i);
    t = fetch_pc_o;
    idle(2);
    @(negedge clk_i);
    assert (fetch_pc_o == t + 16'd8)
      else report_error($sformatf("fetch_pc_o %h redirected while frozen", fetch_pc_o));
    idle(1);
    freeze_i <= 1'b0;
    wait_boot(16);
    sweep_counters(1'b1);
    idle(2);

    $display("Summary: %0d cycles, %0d errors", cycle_cnt, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial
  begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: filelist.f
common/be_pkg.sv
be_director/be_director.sv
rtl/fe_cmd_fifo.sv
rtl/fe_pc_gen.sv
rtl/be_fe_top.sv
sim/tb_be_fe_top.sv
